// File: design/mips_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Shared widths, ALU encodings and pipeline bundles
////////////////////////////////////////////////////////////////////////

package mips_pkg;

	// Datapath word and register index widths
	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;

	// ALU operation select
	typedef enum logic [2:0]
	{
		ADD = 3'd0,
		SUB = 3'd1,
		AND = 3'd2,
		OR  = 3'd3,
		XOR = 3'd4,
		NOR = 3'd5,
		// Signed set-less-than
		SLT = 3'd6
	} alu_op_e;

	// Write-back control group
	typedef struct packed
	{
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

	// Memory-stage control group
	typedef struct packed
	{
		logic jump;
		logic branch;
		logic mem_read;
		logic mem_write;
	} mem_ctrl_t;

	// Decoded instruction entering execute
	typedef struct packed
	{
		logic [DATA_W-1:0]     pc_plus4;
		logic [DATA_W-1:0]     rs_data;
		logic [DATA_W-1:0]     rt_data;
		// Already sign-extended
		logic [DATA_W-1:0]     imm;
		logic [REG_ADDR_W-1:0] rt;
		logic [REG_ADDR_W-1:0] rd;
		logic                  reg_dst;
		logic                  alu_src;
		alu_op_e               alu_op;
		logic [DATA_W-1:0]     jump_target;
		wb_ctrl_t              wb;
		mem_ctrl_t             mem;
	} id_ex_t;

	// EX/MEM latch contents
	typedef struct packed
	{
		logic [DATA_W-1:0]     add_result;
		logic [DATA_W-1:0]     alu_result;
		logic [DATA_W-1:0]     r_data2;
		logic [REG_ADDR_W-1:0] dest;
		logic [DATA_W-1:0]     pc_jump;
		logic                  zero;
		wb_ctrl_t              wb;
		mem_ctrl_t             mem;
	} ex_mem_t;

	// MEM/WB latch contents, also the register-file write port
	typedef struct packed
	{
		logic                  reg_write;
		logic [REG_ADDR_W-1:0] dest;
		logic [DATA_W-1:0]     wb_data;
	} mem_wb_t;

	// PC redirect toward fetch
	typedef struct packed
	{
		logic              taken;
		logic [DATA_W-1:0] target;
	} pc_redirect_t;

endpackage

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Integer ALU, purely combinational
////////////////////////////////////////////////////////////////////////

module alu
(
	input  logic [mips_pkg::DATA_W-1:0] a,
	input  logic [mips_pkg::DATA_W-1:0] b,
	input  mips_pkg::alu_op_e           op,
	output logic [mips_pkg::DATA_W-1:0] result,
	output logic                        zero
);

	// Signed view of the operands for SLT
	logic signed [mips_pkg::DATA_W-1:0] a_s;
	logic signed [mips_pkg::DATA_W-1:0] b_s;

	assign a_s = a;
	assign b_s = b;

	always_comb
	begin
		case (op)
			mips_pkg::ADD:
			begin
				result = a + b;
			end
			mips_pkg::SUB:
			begin
				result = a - b;
			end
			mips_pkg::AND:
			begin
				result = a & b;
			end
			mips_pkg::OR:
			begin
				result = a | b;
			end
			mips_pkg::XOR:
			begin
				result = a ^ b;
			end
			mips_pkg::NOR:
			begin
				result = ~(a | b);
			end
			mips_pkg::SLT:
			begin
				// One in bit 0 when a < b, rest zero
				result = {{(mips_pkg::DATA_W-1){1'b0}}, (a_s < b_s)};
			end
			default:
			begin
				// Unused encoding
				result = '0;
			end
		endcase
	end

	// Branch compare flag
	assign zero = (result == '0);

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Execute stage: ALU, branch-target adder, destination select
////////////////////////////////////////////////////////////////////////

module execute_stage
(
	input  mips_pkg::id_ex_t  id_ex,
	output mips_pkg::ex_mem_t ex_bundle
);

	// Second ALU operand after the immediate mux
	logic [mips_pkg::DATA_W-1:0] alu_b;
	// ALU outputs
	logic [mips_pkg::DATA_W-1:0] alu_result;
	logic                        alu_zero;
	// Word offset for branches
	logic [mips_pkg::DATA_W-1:0] branch_offset;

	// Immediate for I-type, rt for R-type
	assign alu_b = id_ex.alu_src ? id_ex.imm : id_ex.rt_data;

	// Immediate counts words, so scale by four
	assign branch_offset = id_ex.imm << 2;

	alu u_alu
	(
		.a      (id_ex.rs_data),
		.b      (alu_b),
		.op     (id_ex.alu_op),
		.result (alu_result),
		.zero   (alu_zero)
	);

	////////////////////////////////////////////////////////////////////
	// Bundle toward EX/MEM
	////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// Branch target
		ex_bundle.add_result = id_ex.pc_plus4 + branch_offset;
		ex_bundle.alu_result = alu_result;
		ex_bundle.zero       = alu_zero;
		// Store data rides along
		ex_bundle.r_data2    = id_ex.rt_data;
		// rd for R-type, rt for I-type
		ex_bundle.dest       = id_ex.reg_dst ? id_ex.rd : id_ex.rt;
		ex_bundle.pc_jump    = id_ex.jump_target;
		// Control groups pass through unchanged
		ex_bundle.wb         = id_ex.wb;
		ex_bundle.mem        = id_ex.mem;
	end

endmodule

`default_nettype wire

// File: design/pipe_latch.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Pipeline register, any packed payload
////////////////////////////////////////////////////////////////////////

module pipe_latch
#(
	parameter type payload_t = logic [31:0]
)
(
	input  logic     clk,
	input  logic     reset,
	input  payload_t d,
	output payload_t q
);

	// Loads every cycle, no stall or flush
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			// All-zero payload is a bubble
			q <= '0;
		end
		else
		begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

// File: design/memory_stage.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Memory stage: data memory, branch resolve, write-back select
////////////////////////////////////////////////////////////////////////

module memory_stage
#(
	// Words, power of two
	parameter int DEPTH = 64
)
(
	input  logic                   clk,
	input  mips_pkg::ex_mem_t      ex_mem,
	output mips_pkg::pc_redirect_t pc_redirect,
	output mips_pkg::mem_wb_t      mem_bundle
);

	// Word index width
	localparam int ADDR_W = $clog2(DEPTH);

	// Data memory array
	logic [mips_pkg::DATA_W-1:0] mem_array [DEPTH];
	// Word index from the byte address
	logic [ADDR_W-1:0]           word_addr;
	// Memory read port
	logic [mips_pkg::DATA_W-1:0] rd_data;

	// Drop byte offset, wrap modulo DEPTH
	assign word_addr = ex_mem.alu_result[ADDR_W+1:2];

	////////////////////////////////////////////////////////////////////
	// Data memory
	////////////////////////////////////////////////////////////////////

	// Store at the end of the MEM cycle
	always_ff @(posedge clk)
	begin
		if (ex_mem.mem.mem_write)
		begin
			mem_array[word_addr] <= ex_mem.r_data2;
		end
	end

	// Asynchronous read, only on loads
	assign rd_data = ex_mem.mem.mem_read ? mem_array[word_addr] : '0;

	////////////////////////////////////////////////////////////////////
	// Branch and jump resolution
	////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// Jump always, branch on equal
		pc_redirect.taken = ex_mem.mem.jump | (ex_mem.mem.branch & ex_mem.zero);
		// Jump wins over the branch adder
		if (ex_mem.mem.jump)
		begin
			pc_redirect.target = ex_mem.pc_jump;
		end
		else
		begin
			pc_redirect.target = ex_mem.add_result;
		end
	end

	////////////////////////////////////////////////////////////////////
	// Write-back select
	////////////////////////////////////////////////////////////////////

	always_comb
	begin
		mem_bundle.reg_write = ex_mem.wb.reg_write;
		mem_bundle.dest      = ex_mem.dest;
		// Load data or ALU result
		mem_bundle.wb_data   = ex_mem.wb.mem_to_reg ? rd_data : ex_mem.alu_result;
	end

endmodule

`default_nettype wire

// File: design/mips_backend.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Pipeline back end: EX, EX/MEM, MEM, MEM/WB
////////////////////////////////////////////////////////////////////////

module mips_backend
#(
	// Data memory size in words
	parameter int DMEM_DEPTH = 64
)
(
	input  logic                   clk,
	input  logic                   reset,
	input  mips_pkg::id_ex_t       id_ex,
	output mips_pkg::pc_redirect_t pc_redirect,
	output mips_pkg::mem_wb_t      reg_wr
);

	// Execute result before the latch
	mips_pkg::ex_mem_t ex_bundle;
	// EX/MEM latch output
	mips_pkg::ex_mem_t ex_mem;
	// Write-back value before the latch
	mips_pkg::mem_wb_t mem_bundle;

	////////////////////////////////////////////////////////////////////
	// EX
	////////////////////////////////////////////////////////////////////

	execute_stage u_execute
	(
		.id_ex     (id_ex),
		.ex_bundle (ex_bundle)
	);

	pipe_latch #(.payload_t(mips_pkg::ex_mem_t)) u_ex_mem
	(
		.clk   (clk),
		.reset (reset),
		.d     (ex_bundle),
		.q     (ex_mem)
	);

	////////////////////////////////////////////////////////////////////
	// MEM and WB
	////////////////////////////////////////////////////////////////////

	memory_stage #(.DEPTH(DMEM_DEPTH)) u_memory
	(
		.clk         (clk),
		.ex_mem      (ex_mem),
		.pc_redirect (pc_redirect),
		.mem_bundle  (mem_bundle)
	);

	// Register-file write port comes out of this latch
	pipe_latch #(.payload_t(mips_pkg::mem_wb_t)) u_mem_wb
	(
		.clk   (clk),
		.reset (reset),
		.d     (mem_bundle),
		.q     (reg_wr)
	);

endmodule

`default_nettype wire

// File: tb/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

// 8 ns clock, reset held for three cycles
module clock_gen
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Release on a falling edge, away from the latch edge
	initial
	begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: tb/tb_mips_backend.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mips_backend;

	localparam int DEPTH = 64;
	localparam int AW    = $clog2(DEPTH);
	// 57 issued bundles plus one idle cycle after reset
	localparam int ISSUES      = 58;
	// Reset plus issues plus pipeline depth and margin
	localparam int CYCLE_LIMIT = 3 + ISSUES + 2 + 20;

	logic                   clk;
	logic                   reset;
	mips_pkg::id_ex_t       id_ex;
	mips_pkg::pc_redirect_t pc_redirect;
	mips_pkg::mem_wb_t      reg_wr;

	integer seed;
	int     errors = 0;
	int     cycles = 0;
	// Expected outputs of the last issue and the one before
	mips_pkg::pc_redirect_t exp_pc;
	mips_pkg::mem_wb_t      exp_wr1;
	mips_pkg::mem_wb_t      exp_wr2;
	// Data memory model written in issue order
	logic [31:0] model_mem [DEPTH];

	clock_gen u_clock
	(
		.clk   (clk),
		.reset (reset)
	);

	mips_backend #(.DMEM_DEPTH(DEPTH)) DUT
	(
		.clk         (clk),
		.reset       (reset),
		.id_ex       (id_ex),
		.pc_redirect (pc_redirect),
		.reg_wr      (reg_wr)
	);

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
	end

	// Watchdog
	initial
	begin
		wait (cycles >= CYCLE_LIMIT);
		$display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
		$display("Finished with errors");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model and checks
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] ref_alu(input mips_pkg::alu_op_e op,
		input logic [31:0] a, input logic [31:0] b);
		case (op)
			mips_pkg::ADD: return a + b;
			mips_pkg::SUB: return a - b;
			mips_pkg::AND: return a & b;
			mips_pkg::OR:  return a | b;
			mips_pkg::XOR: return a ^ b;
			mips_pkg::NOR: return ~(a | b);
			// Signed compare
			mips_pkg::SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default:       return 32'd0;
		endcase
	endfunction

	task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
			errors++;
		end
	endtask

	// Check earlier issues before driving b and predicting its results
	task automatic issue(input mips_pkg::id_ex_t b);
		logic [31:0]   opnd;
		logic [31:0]   res;
		logic [AW-1:0] idx;
		@(negedge clk);
		// pc_redirect lags one issue and reg_wr two
		check({31'd0, pc_redirect}, {31'd0, exp_pc}, "pc_redirect");
		check({26'd0, reg_wr}, {26'd0, exp_wr2}, "reg_wr");
		exp_wr2 = exp_wr1;
		opnd = b.alu_src ? b.imm : b.rt_data;
		res  = ref_alu(b.alu_op, b.rs_data, opnd);
		idx  = res[AW+1:2];
		exp_pc.taken  = b.mem.jump | (b.mem.branch & (res == 32'd0));
		exp_pc.target = b.mem.jump ? b.jump_target : b.pc_plus4 + (b.imm << 2);
		exp_wr1.reg_write = b.wb.reg_write;
		exp_wr1.dest      = b.reg_dst ? b.rd : b.rt;
		exp_wr1.wb_data   = b.wb.mem_to_reg ? model_mem[idx] : res;
		// Read above sees the old word like the hardware does
		if (b.mem.mem_write)
		begin
			model_mem[idx] = b.rt_data;
		end
		id_ex = b;
	endtask

	// Load or store at a byte address with zero offset
	function automatic mips_pkg::id_ex_t mem_op(input logic store, input logic [31:0] addr,
		input logic [31:0] data, input logic [4:0] rt);
		mips_pkg::id_ex_t b;
		b             = '0;
		b.rs_data     = addr;
		b.rt_data     = data;
		b.rt          = rt;
		b.alu_src     = 1'b1;
		b.alu_op      = mips_pkg::ADD;
		b.mem.mem_write = store;
		b.mem.mem_read  = ~store;
		b.wb.reg_write  = ~store;
		b.wb.mem_to_reg = ~store;
		return b;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic idle_after_reset();
		// Latches still clear at release despite the live bundle
		check({63'd0, reg_wr.reg_write}, 64'd0, "reg_write at reset release");
		check({63'd0, pc_redirect.taken}, 64'd0, "taken at reset release");
		id_ex = '0;
		@(negedge clk);
		check({63'd0, reg_wr.reg_write}, 64'd0, "reg_write after reset");
		check({63'd0, pc_redirect.taken}, 64'd0, "taken after reset");
		repeat (3) issue('0);
	endtask

	// Each op as R-type and then as I-type with rt as dest
	task automatic every_alu_op();
		mips_pkg::id_ex_t b;
		logic [31:0]      w;
		for (int i = 0; i < 7; i++)
		begin
			for (int k = 0; k < 2; k++)
			begin
				b = '0;
				b.alu_op       = mips_pkg::alu_op_e'(i[2:0]);
				b.rs_data      = $random(seed);
				b.rt_data      = $random(seed);
				b.imm          = $random(seed);
				w              = $random(seed);
				b.rd           = w[4:0];
				// Nonzero xor keeps rt apart from rd
				b.rt           = w[4:0] ^ (w[9:5] | 5'd1);
				b.reg_dst      = (k == 0);
				b.alu_src      = (k == 1);
				b.wb.reg_write = 1'b1;
				issue(b);
				issue('0);
			end
		end
	endtask

	// Taken only on equal operands
	task automatic branch_compare();
		mips_pkg::id_ex_t b;
		for (int k = 0; k < 2; k++)
		begin
			b = '0;
			b.alu_op     = mips_pkg::SUB;
			b.pc_plus4   = $random(seed) & 32'hffff_fffc;
			b.imm        = $random(seed);
			b.rs_data    = $random(seed);
			b.rt_data    = b.rs_data + k;
			b.mem.branch = 1'b1;
			issue(b);
			issue('0);
		end
	endtask

	// Zero flag set on the first jump and clear on the second
	task automatic jump_redirect();
		mips_pkg::id_ex_t b;
		for (int k = 0; k < 2; k++)
		begin
			b = '0;
			b.alu_op      = mips_pkg::SUB;
			b.pc_plus4    = $random(seed);
			b.imm         = $random(seed);
			b.rs_data     = $random(seed);
			b.rt_data     = b.rs_data + k;
			b.jump_target = $random(seed);
			b.mem.jump    = 1'b1;
			issue(b);
			issue('0);
		end
	endtask

	task automatic store_then_load();
		logic [31:0] a1;
		logic [31:0] a2;
		a1 = $random(seed);
		// Neighbouring word with its own index
		a2 = a1 + 32'd4;
		issue(mem_op(1'b1, a1, $random(seed), 5'd0));
		issue(mem_op(1'b0, a1, 32'd0, 5'd7));
		issue('0);
		issue(mem_op(1'b1, a2, $random(seed), 5'd0));
		issue('0);
		issue(mem_op(1'b0, a1, 32'd0, 5'd12));
		issue(mem_op(1'b0, a2, 32'd0, 5'd31));
		issue('0);
	endtask

	// Three in flight with no bubbles
	task automatic back_to_back();
		mips_pkg::id_ex_t b;
		logic [31:0]      w;
		for (int i = 0; i < 6; i++)
		begin
			b = '0;
			w = $random(seed);
			b.alu_op       = mips_pkg::alu_op_e'(i[2:0]);
			b.rs_data      = $random(seed);
			b.rt_data      = $random(seed);
			b.imm          = $random(seed);
			b.rd           = w[4:0];
			b.rt           = w[4:0] ^ (w[9:5] | 5'd1);
			b.reg_dst      = w[10];
			b.alu_src      = w[11];
			b.wb.reg_write = 1'b1;
			issue(b);
		end
		issue('0);
		issue('0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		seed    = 32'ha05e;
		// Live bundle during reset that the latches must not capture
		id_ex   = '0;
		id_ex.wb.reg_write = 1'b1;
		id_ex.mem.jump     = 1'b1;
		exp_pc  = '0;
		exp_wr1 = '0;
		exp_wr2 = '0;
		wait (reset === 1'b0);
		idle_after_reset();
		every_alu_op();
		branch_compare();
		jump_redirect();
		store_then_load();
		back_to_back();
		// Drain the last two issues through the checks
		issue('0);
		issue('0);
		$display("errors: %0d", errors);
		if (errors == 0)
		begin
			$display("Finished with no errors");
		end
		else
		begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
design/mips_pkg.sv
design/alu.sv
design/execute_stage.sv
design/pipe_latch.sv
design/memory_stage.sv
design/mips_backend.sv
tb/clock_gen.sv
tb/tb_mips_backend.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ns -f filelist.f \
		--top-module tb_mips_backend -Mdir obj_dir
	./obj_dir/Vtb_mips_backend | tee sim.log
	grep -q "^Finished with no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
